// File: include/boot_rom_image.svh
`ifndef BOOT_ROM_IMAGE_SVH
`define BOOT_ROM_IMAGE_SVH

`define BOOT_ROM_WORDS 16

// Boot loader stub, one instruction word per entry
`define BOOT_ROM_IMAGE '{ \
	32'h3c08_8000, 32'h3509_0400, 32'h2402_0000, 32'h2403_0040, \
	32'h8d0a_0000, 32'had2a_0000, 32'h2508_0004, 32'h2529_0004, \
	32'h2442_0001, 32'h1443_fffa, 32'h0000_0000, 32'h3c1f_8000, \
	32'h03e0_0008, 32'h0000_0000, 32'hdead_beef, 32'h1234_5678  \
}

`endif

// File: design/soc_bus_pkg.sv
package soc_bus_pkg;

	// Host side widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  dev_sel_t;

	// Device select codes
	localparam dev_sel_t SEL_NONE      = 4'd0;
	localparam dev_sel_t SEL_RAM       = 4'd1;
	localparam dev_sel_t SEL_ROM       = 4'd2;
	localparam dev_sel_t SEL_UART      = 4'd5;
	localparam dev_sel_t SEL_UART_STAT = 4'd6;
	localparam dev_sel_t SEL_DIGSEG    = 4'd7;

	// Codes 3, 4 and 8..15 have no device behind them

endpackage

// File: design/soc_periph_pkg.sv
package soc_periph_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [3:0] nibble_t;

	// Bit 6 is segment a, bit 0 is segment g
	typedef logic [6:0] seg_t;

	function automatic seg_t hex_to_seg(nibble_t digit);
		seg_t seg;
		case (digit)
			4'h0: seg = 7'h7e;
			4'h1: seg = 7'h30;
			4'h2: seg = 7'h6d;
			4'h3: seg = 7'h79;
			4'h4: seg = 7'h33;
			4'h5: seg = 7'h5b;
			4'h6: seg = 7'h5f;
			4'h7: seg = 7'h70;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h7b;
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h1f;
			4'hc: seg = 7'h4e;
			4'hd: seg = 7'h3d;
			4'he: seg = 7'h4f;
			default: seg = 7'h47;
		endcase
		return seg;
	endfunction

endpackage

// File: design/bus_ctrl.sv
module bus_ctrl import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     rst_n_i,

	input  logic     req_stb_i,
	input  logic     req_we_i,
	input  dev_sel_t req_sel_i,
	input  addr_t    req_addr_i,
	input  word_t    req_wdata_i,

	input  logic     ram_ack_i,
	input  word_t    ram_rdata_i,
	input  logic     rom_ack_i,
	input  word_t    rom_rdata_i,
	input  logic     seg_ack_i,
	input  word_t    seg_rdata_i,
	input  logic     tx_busy_i,

	output logic     ram_stb_o,
	output logic     rom_stb_o,
	output logic     uart_stb_o,
	output logic     seg_stb_o,
	output logic     tgt_we_o,
	output addr_t    tgt_addr_o,
	output word_t    tgt_wdata_o,

	output logic     rsp_ack_o,
	output word_t    rsp_rdata_o
);

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WAIT_TGT,
		WAIT_UART,
		RESP
	} state_t;

	state_t   state_q;
	dev_sel_t sel_q;
	logic     issue;

	assign issue = (state_q == ISSUE);

	// One strobe per target, only in ISSUE
	assign ram_stb_o  = issue && (sel_q == SEL_RAM);
	assign rom_stb_o  = issue && (sel_q == SEL_ROM);
	assign seg_stb_o  = issue && (sel_q == SEL_DIGSEG);
	assign uart_stb_o = issue && (sel_q == SEL_UART) && tgt_we_o;

	assign rsp_ack_o = (state_q == RESP);

	// Request latched once, shared by all targets
	always_ff @(posedge clk) begin
		if (state_q == IDLE && req_stb_i) begin
			sel_q       <= req_sel_i;
			tgt_we_o    <= req_we_i;
			tgt_addr_o  <= req_addr_i;
			tgt_wdata_o <= req_wdata_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q     <= IDLE;
			rsp_rdata_o <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (req_stb_i)
						state_q <= ISSUE;
				end
				ISSUE: begin
					if (sel_q == SEL_UART && tgt_we_o)
						state_q <= WAIT_UART;
					else
						state_q <= WAIT_TGT;
				end
				WAIT_TGT: begin
					case (sel_q)
						SEL_RAM: begin
							if (ram_ack_i) begin
								rsp_rdata_o <= ram_rdata_i;
								state_q     <= RESP;
							end
						end
						SEL_ROM: begin
							if (rom_ack_i) begin
								rsp_rdata_o <= rom_rdata_i;
								state_q     <= RESP;
							end
						end
						SEL_DIGSEG: begin
							if (seg_ack_i) begin
								rsp_rdata_o <= seg_rdata_i;
								state_q     <= RESP;
							end
						end
						SEL_UART_STAT: begin
							rsp_rdata_o <= {31'b0, tx_busy_i};
							state_q     <= RESP;
						end
						// SEL_NONE, unmapped codes and UART reads
						default: begin
							rsp_rdata_o <= '0;
							state_q     <= RESP;
						end
					endcase
				end
				WAIT_UART: begin
					// Frame is done once the transmitter drops busy
					if (!tx_busy_i) begin
						rsp_rdata_o <= '0;
						state_q     <= RESP;
					end
				end
				RESP: begin
					state_q <= IDLE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

endmodule

// File: design/sram_block.sv
module sram_block import soc_bus_pkg::*; #(
	parameter int RAM_AW = 8
) (
	input  logic  clk,
	input  logic  stb_i,
	input  logic  we_i,
	input  addr_t addr_i,
	input  word_t wdata_i,
	output logic  ack_o,
	output word_t rdata_o
);

	localparam int DEPTH = 2 ** RAM_AW;

	word_t             mem [DEPTH];
	logic [RAM_AW-1:0] waddr;

	// Byte address, word aligned
	assign waddr = addr_i[RAM_AW+1:2];

	always_ff @(posedge clk) begin
		if (stb_i) begin
			if (we_i)
				mem[waddr] <= wdata_i;
			else
				rdata_o <= mem[waddr];
		end
	end

	// Answer one cycle after the strobe
	always_ff @(posedge clk) begin
		ack_o <= stb_i;
	end

endmodule

// File: design/boot_rom.sv
`include "boot_rom_image.svh"

module boot_rom import soc_bus_pkg::*; #(
	parameter int ROM_AW = 4
) (
	input  logic  clk,
	input  logic  stb_i,
	input  logic  we_i,
	input  addr_t addr_i,
	output logic  ack_o,
	output word_t rdata_o
);

	localparam int    ROM_WORDS = `BOOT_ROM_WORDS;
	localparam word_t IMAGE [ROM_WORDS] = `BOOT_ROM_IMAGE;

	logic [ROM_AW-1:0] idx;
	word_t             rom_word;

	assign idx = addr_i[ROM_AW+1:2];

	// Past the end of the image reads as zero
	assign rom_word = (idx < ROM_WORDS) ? IMAGE[idx] : '0;

	always_ff @(posedge clk) begin
		if (stb_i)
			rdata_o <= we_i ? '0 : rom_word;
		ack_o <= stb_i;
	end

endmodule

// File: design/baud_timer.sv
module baud_timer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic restart_i,
	output logic tick_o
);

	localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

	logic [CW-1:0] cnt_q;

	assign tick_o = (cnt_q == LAST);

	// Restart lines bit boundaries up with the frame start
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (restart_i || cnt_q == LAST) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

endmodule

// File: design/uart_tx.sv
module uart_tx import soc_periph_pkg::*; (
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  stb_i,
	input  byte_t data_i,
	input  logic  tick_i,
	output logic  restart_o,
	output logic  busy_o,
	output logic  tx_o
);

	logic [9:0] frame_q;
	logic [3:0] bit_q;
	logic       load;

	assign load      = stb_i && !busy_o;
	assign restart_o = load;

	// Stop bit, data LSB first, start bit
	always_ff @(posedge clk) begin
		if (load)
			frame_q <= {1'b1, data_i, 1'b0};
		else if (busy_o && tick_i)
			frame_q <= frame_q >> 1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_o <= 1'b0;
			tx_o   <= 1'b1;
			bit_q  <= '0;
		end else if (load) begin
			busy_o <= 1'b1;
			tx_o   <= 1'b0;
			bit_q  <= '0;
		end else if (busy_o && tick_i) begin
			if (bit_q == 4'd9) begin
				// End of stop bit, back to idle
				busy_o <= 1'b0;
				tx_o   <= 1'b1;
			end else begin
				tx_o  <= frame_q[1];
				bit_q <= bit_q + 1'b1;
			end
		end
	end

endmodule

// File: design/seg_display.sv
module seg_display import soc_bus_pkg::*, soc_periph_pkg::*; (
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  stb_i,
	input  logic  we_i,
	input  word_t wdata_i,
	output logic  ack_o,
	output word_t rdata_o,
	output seg_t  seg1_o,
	output seg_t  seg0_o
);

	nibble_t dig1_q;
	nibble_t dig0_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			dig1_q <= '0;
			dig0_q <= '0;
			ack_o  <= 1'b0;
		end else begin
			ack_o <= stb_i;
			if (stb_i && we_i) begin
				dig1_q <= wdata_i[7:4];
				dig0_q <= wdata_i[3:0];
			end
		end
	end

	// Readback of both digits
	always_ff @(posedge clk) begin
		if (stb_i && !we_i)
			rdata_o <= {24'b0, dig1_q, dig0_q};
	end

	// Registered glyphs, one cycle behind the digits
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			seg1_o <= hex_to_seg(4'h0);
			seg0_o <= hex_to_seg(4'h0);
		end else begin
			seg1_o <= hex_to_seg(dig1_q);
			seg0_o <= hex_to_seg(dig0_q);
		end
	end

endmodule

// File: design/soc_bus_top.sv
module soc_bus_top import soc_bus_pkg::*, soc_periph_pkg::*; #(
	parameter int RAM_AW       = 8,
	parameter int ROM_AW       = 4,
	parameter int CLKS_PER_BIT = 8
) (
	input  logic     clk,
	input  logic     rst_n_i,

	input  logic     req_stb_i,
	input  logic     req_we_i,
	input  dev_sel_t req_sel_i,
	input  addr_t    req_addr_i,
	input  word_t    req_wdata_i,

	output logic     rsp_ack_o,
	output word_t    rsp_rdata_o,
	output logic     tx_o,
	output logic     tx_busy_o,
	output seg_t     seg1_o,
	output seg_t     seg0_o
);

	logic  ram_stb, rom_stb, uart_stb, seg_stb;
	logic  ram_ack, rom_ack, seg_ack;
	word_t ram_rdata, rom_rdata, seg_rdata;
	logic  tgt_we;
	addr_t tgt_addr;
	word_t tgt_wdata;
	logic  tx_busy;
	logic  bit_restart;
	logic  bit_tick;

	assign tx_busy_o = tx_busy;

	bus_ctrl u_bus_ctrl (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_stb_i  (req_stb_i),
		.req_we_i   (req_we_i),
		.req_sel_i  (req_sel_i),
		.req_addr_i (req_addr_i),
		.req_wdata_i(req_wdata_i),
		.ram_ack_i  (ram_ack),
		.ram_rdata_i(ram_rdata),
		.rom_ack_i  (rom_ack),
		.rom_rdata_i(rom_rdata),
		.seg_ack_i  (seg_ack),
		.seg_rdata_i(seg_rdata),
		.tx_busy_i  (tx_busy),
		.ram_stb_o  (ram_stb),
		.rom_stb_o  (rom_stb),
		.uart_stb_o (uart_stb),
		.seg_stb_o  (seg_stb),
		.tgt_we_o   (tgt_we),
		.tgt_addr_o (tgt_addr),
		.tgt_wdata_o(tgt_wdata),
		.rsp_ack_o  (rsp_ack_o),
		.rsp_rdata_o(rsp_rdata_o)
	);

	sram_block #(.RAM_AW(RAM_AW)) u_sram (
		.clk    (clk),
		.stb_i  (ram_stb),
		.we_i   (tgt_we),
		.addr_i (tgt_addr),
		.wdata_i(tgt_wdata),
		.ack_o  (ram_ack),
		.rdata_o(ram_rdata)
	);

	boot_rom #(.ROM_AW(ROM_AW)) u_rom (
		.clk    (clk),
		.stb_i  (rom_stb),
		.we_i   (tgt_we),
		.addr_i (tgt_addr),
		.ack_o  (rom_ack),
		.rdata_o(rom_rdata)
	);

	baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_baud (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.restart_i(bit_restart),
		.tick_o   (bit_tick)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.stb_i    (uart_stb),
		.data_i   (tgt_wdata[7:0]),
		.tick_i   (bit_tick),
		.restart_o(bit_restart),
		.busy_o   (tx_busy),
		.tx_o     (tx_o)
	);

	seg_display u_seg (
		.clk    (clk),
		.rst_n_i(rst_n_i),
		.stb_i  (seg_stb),
		.we_i   (tgt_we),
		.wdata_i(tgt_wdata),
		.ack_o  (seg_ack),
		.rdata_o(seg_rdata),
		.seg1_o (seg1_o),
		.seg0_o (seg0_o)
	);

endmodule

// File: dv/soc_bus_sva.sv
module bus_ctrl_sva (
	input logic clk,
	input logic rst_n_i,
	input logic req_stb_i,
	input logic rsp_ack_i,
	input logic ram_stb_i,
	input logic rom_stb_i,
	input logic uart_stb_i,
	input logic seg_stb_i
);

	timeunit 1ns;
	timeprecision 100ps;

	logic pending_q;

	// Open request, from the cycle after the strobe through the ack cycle
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			pending_q <= 1'b0;
		else if (rsp_ack_i)
			pending_q <= 1'b0;
		else if (req_stb_i)
			pending_q <= 1'b1;
	end

	ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_ack_i |=> !rsp_ack_i)
		else $error("rsp_ack_o held for more than one cycle");

	no_strobe_while_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
		pending_q |-> !req_stb_i)
		else $error("request strobe while controller busy");

	one_target_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0({ram_stb_i, rom_stb_i, uart_stb_i, seg_stb_i}))
		else $error("more than one target strobe high");

endmodule

bind bus_ctrl bus_ctrl_sva u_bus_ctrl_sva (
	.clk       (clk),
	.rst_n_i   (rst_n_i),
	.req_stb_i (req_stb_i),
	.rsp_ack_i (rsp_ack_o),
	.ram_stb_i (ram_stb_o),
	.rom_stb_i (rom_stb_o),
	.uart_stb_i(uart_stb_o),
	.seg_stb_i (seg_stb_o)
);

// File: dv/soc_bus_tb.sv
`include "boot_rom_image.svh"

module soc_bus_tb import soc_bus_pkg::*, soc_periph_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAM_AW       = 8;
	localparam int ROM_AW       = 4;
	localparam int CLKS_PER_BIT = 8;

	localparam int N_RAM   = 64;
	localparam int N_SEG   = 8;
	localparam int N_UART  = 8;
	localparam int N_UNMAP = 11;
	// Bus requests over all tests, about four cycles each
	localparam int N_REQ = 2 * N_RAM + 18 + 2 * N_SEG + 2 * N_UART + 2 * N_UNMAP + 2;
	localparam int MAX_CYCLES = 16 + 4 * N_REQ + 12 * 10 * CLKS_PER_BIT + 100;

	localparam word_t ROM_IMAGE [`BOOT_ROM_WORDS] = `BOOT_ROM_IMAGE;

	logic     clk;
	logic     rst_n_i;
	logic     req_stb_i;
	logic     req_we_i;
	dev_sel_t req_sel_i;
	addr_t    req_addr_i;
	word_t    req_wdata_i;
	logic     rsp_ack_o;
	word_t    rsp_rdata_o;
	logic     tx_o;
	logic     tx_busy_o;
	seg_t     seg1_o;
	seg_t     seg0_o;

	word_t  shadow_ram [2 ** RAM_AW];
	byte_t  shadow_seg;
	byte_t  rx_q [$];
	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	int     cycle_cnt = 0;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	soc_bus_top #(
		.RAM_AW      (RAM_AW),
		.ROM_AW      (ROM_AW),
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) dut (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_stb_i  (req_stb_i),
		.req_we_i   (req_we_i),
		.req_sel_i  (req_sel_i),
		.req_addr_i (req_addr_i),
		.req_wdata_i(req_wdata_i),
		.rsp_ack_o  (rsp_ack_o),
		.rsp_rdata_o(rsp_rdata_o),
		.tx_o       (tx_o),
		.tx_busy_o  (tx_busy_o),
		.seg1_o     (seg1_o),
		.seg0_o     (seg0_o)
	);

	// Expected response word; writes update the shadow state
	function automatic word_t expected_read(dev_sel_t sel, logic we, addr_t addr, word_t wdata);
		word_t exp;
		exp = '0;
		case (sel)
			SEL_RAM: begin
				if (we)
					shadow_ram[addr[RAM_AW+1:2]] = wdata;
				else
					exp = shadow_ram[addr[RAM_AW+1:2]];
			end
			SEL_ROM: begin
				if (!we)
					exp = ROM_IMAGE[addr[ROM_AW+1:2]];
			end
			SEL_DIGSEG: begin
				if (we)
					shadow_seg = wdata[7:0];
				else
					exp = {24'b0, shadow_seg};
			end
			// Transmitter idle once the write was acknowledged
			default: exp = '0;
		endcase
		return exp;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic issue_request(input dev_sel_t sel, input logic we, input addr_t addr,
			input word_t wdata, output word_t rdata);
		int lat;
		@(posedge clk);
		req_stb_i   <= 1'b1;
		req_sel_i   <= sel;
		req_we_i    <= we;
		req_addr_i  <= addr;
		req_wdata_i <= wdata;
		@(posedge clk);
		req_stb_i <= 1'b0;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!rsp_ack_o);
		rdata = rsp_rdata_o;
		// UART writes last as long as the frame
		if (!(sel == SEL_UART && we))
			check_word($sformatf("latency sel %0d", sel), 32'd3, word_t'(lat));
	endtask

	task automatic run_access(input string name, input dev_sel_t sel, input logic we,
			input addr_t addr, input word_t wdata);
		word_t exp;
		word_t act;
		exp = expected_read(sel, we, addr, wdata);
		issue_request(sel, we, addr, wdata, act);
		// RAM and display give no defined data on a write
		if (!(we && (sel == SEL_RAM || sel == SEL_DIGSEG)))
			check_word(name, exp, act);
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		$display("test %s finished with %0d errors", name, errors - err_before);
	endtask

	// Line decoder, samples near the middle of each bit
	initial begin : uart_monitor
		byte_t rx_byte;
		forever begin
			@(negedge tx_o);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			check_word("uart start bit", 32'd0, word_t'(tx_o));
			check_word("uart busy at start", 32'd1, word_t'(tx_busy_o));
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				rx_byte[i] = tx_o;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			check_word("uart stop bit", 32'd1, word_t'(tx_o));
			check_word("uart busy at stop", 32'd1, word_t'(tx_busy_o));
			rx_q.push_back(rx_byte);
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		addr_t ram_addr [N_RAM];
		word_t wd;
		int    err0;
		seed        = 32'hfea8;
		shadow_seg  = '0;
		rst_n_i     = 1'b0;
		req_stb_i   = 1'b0;
		req_we_i    = 1'b0;
		req_sel_i   = SEL_NONE;
		req_addr_i  = '0;
		req_wdata_i = '0;
		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);

		err0 = errors;
		check_word("reset ack", 32'd0, word_t'(rsp_ack_o));
		check_word("reset tx", 32'd1, word_t'(tx_o));
		check_word("reset busy", 32'd0, word_t'(tx_busy_o));
		check_word("reset seg1", word_t'(hex_to_seg(4'h0)), word_t'(seg1_o));
		check_word("reset seg0", word_t'(hex_to_seg(4'h0)), word_t'(seg0_o));
		report_test("reset", err0);

		err0 = errors;
		for (int i = 0; i < N_RAM; i++) begin
			ram_addr[i] = $random(seed);
			run_access("ram write", SEL_RAM, 1'b1, ram_addr[i], $random(seed));
		end
		for (int i = 0; i < N_RAM; i++)
			run_access("ram read", SEL_RAM, 1'b0, ram_addr[i], '0);
		report_test("ram", err0);

		err0 = errors;
		for (int i = 0; i < `BOOT_ROM_WORDS; i++)
			run_access("rom read", SEL_ROM, 1'b0, addr_t'(i * 4), '0);
		run_access("rom write", SEL_ROM, 1'b1, 32'h14, $random(seed));
		run_access("rom read after write", SEL_ROM, 1'b0, 32'h14, '0);
		report_test("rom", err0);

		err0 = errors;
		for (int i = 0; i < N_SEG; i++) begin
			wd = $random(seed);
			run_access("seg write", SEL_DIGSEG, 1'b1, '0, wd);
			check_word("seg1 glyph", word_t'(hex_to_seg(wd[7:4])), word_t'(seg1_o));
			check_word("seg0 glyph", word_t'(hex_to_seg(wd[3:0])), word_t'(seg0_o));
			run_access("seg read", SEL_DIGSEG, 1'b0, '0, '0);
		end
		report_test("display", err0);

		err0 = errors;
		for (int i = 0; i < N_UART; i++) begin
			wd = $random(seed);
			run_access("uart write", SEL_UART, 1'b1, '0, wd);
			checks++;
			assert (rx_q.size() > 0) else begin
				errors++;
				$display("no byte decoded from the tx line after uart write %0d", i);
			end
			if (rx_q.size() > 0)
				check_word("uart byte", word_t'(wd[7:0]), word_t'(rx_q.pop_front()));
			run_access("uart status", SEL_UART_STAT, 1'b0, '0, '0);
		end
		report_test("uart", err0);

		err0 = errors;
		for (int s = 0; s < 16; s++) begin
			if (dev_sel_t'(s) inside {SEL_RAM, SEL_ROM, SEL_UART, SEL_UART_STAT, SEL_DIGSEG})
				continue;
			run_access("unmapped write", dev_sel_t'(s), 1'b1, ram_addr[0], $random(seed));
			run_access("unmapped read", dev_sel_t'(s), 1'b0, ram_addr[0], '0);
		end
		run_access("ram after unmapped", SEL_RAM, 1'b0, ram_addr[0], '0);
		run_access("seg after unmapped", SEL_DIGSEG, 1'b0, '0, '0);
		report_test("unmapped", err0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/bus_ctrl.sv
design/sram_block.sv
design/boot_rom.sv
design/baud_timer.sv
design/uart_tx.sv
design/seg_display.sv
design/soc_bus_top.sv
dv/soc_bus_sva.sv
dv/soc_bus_tb.sv
